// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

   // bus widths
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [data_w-1:0] data_t;
   typedef logic [strb_w-1:0] strb_t;

   ////////////////////////////////////////////////////////////////////////////
   // address map
   ////////////////////////////////////////////////////////////////////////////

   localparam addr_t addr_snap_status    = 32'h00;
   localparam addr_t addr_action_type    = 32'h10;
   localparam addr_t addr_action_version = 32'h14;
   localparam addr_t addr_snap_context   = 32'h20;
   localparam addr_t addr_status_l       = 32'h30;
   localparam addr_t addr_status_h       = 32'h34;
   localparam addr_t addr_control        = 32'h38;
   localparam addr_t addr_packet_init_l  = 32'h40;
   localparam addr_t addr_packet_init_h  = 32'h44;
   localparam addr_t addr_stat_init_l    = 32'h58;
   localparam addr_t addr_stat_init_h    = 32'h5C;
   localparam addr_t addr_packet_total   = 32'h60;
   localparam addr_t addr_stat_space     = 32'h70;
   localparam addr_t addr_self_test_l    = 32'hC0;
   localparam addr_t addr_self_test_h    = 32'hC4;

   // reset and fill values
   localparam logic [63:0] self_test_reset = 64'h0000_0000_DEAD_BEEF;
   localparam data_t       unmapped_data   = 32'h5A5A_A5A5;
   localparam logic [1:0]  resp_okay       = 2'b00;

   // control word, bit 0 at the bottom
   typedef struct packed {
      logic [26:0] spare;
      logic        disable_axi_write;
      logic        core_soft_reset;
      logic        result_flush;
      logic        stat_enable;
      logic        packet_enable;
   } ctrl_bits_t;

   // written as a raw word, consumed as fields
   typedef union packed {
      data_t      raw;
      ctrl_bits_t bits;
   } ctrl_word_u;

   ////////////////////////////////////////////////////////////////////////////
   // status snapshot layout
   ////////////////////////////////////////////////////////////////////////////

   localparam int status_w                = 64;
   localparam int stat_pos_exhausted      = 0;
   localparam int stat_pos_complete       = 1;
   localparam int stat_pos_flush_done     = 2;
   localparam int stat_pos_space_depleted = 3;
   localparam int stat_pos_buffer_valid   = 4;
   localparam int stat_pos_run_out        = 5;
   localparam int stat_err_lsb            = 8;
   localparam int err_w                   = 16;
   localparam int stat_total_lsb          = 32;

endpackage

`default_nettype wire

// File: verilog/reg_bus_if.sv
`default_nettype none

// register access requests from the bus controller to the datapath
interface reg_bus_if;
   import csr_pkg::*;

   logic  wr_en;
   addr_t wr_addr;
   data_t wr_data;
   strb_t wr_strb;
   logic  rd_en;
   addr_t rd_addr;

   modport ctrl (
      output wr_en,
      output wr_addr,
      output wr_data,
      output wr_strb,
      output rd_en,
      output rd_addr
   );

   modport target (
      input wr_en,
      input wr_addr,
      input wr_data,
      input wr_strb,
      input rd_en,
      input rd_addr
   );

endinterface

`default_nettype wire

// File: verilog/axil_handshake.sv
`default_nettype none

module axil_handshake (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           awvalid,
   input  csr_pkg::addr_t awaddr,
   output logic           awready,
   input  logic           wvalid,
   input  csr_pkg::data_t wdata,
   input  csr_pkg::strb_t wstrb,
   output logic           wready,
   output logic           bvalid,
   input  logic           bready,
   input  logic           arvalid,
   input  csr_pkg::addr_t araddr,
   output logic           arready,
   output logic           rvalid,
   input  logic           rready,
   reg_bus_if.ctrl        bus
);

   ////////////////////////////////////////////////////////////////////////////
   // write side
   ////////////////////////////////////////////////////////////////////////////

   // awready comes up as soon as an address is offered
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         awready <= 1'b0;
      end else if (awvalid) begin
         awready <= 1'b1;
      end else if (wvalid && wready) begin
         awready <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         bus.wr_addr <= awaddr;
      end
   end

   // data phase opens after the address handshake
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wready <= 1'b0;
      end else if (awvalid && awready) begin
         wready <= 1'b1;
      end else if (wvalid) begin
         wready <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bvalid <= 1'b0;
      end else if (wvalid && wready) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   assign bus.wr_en   = wvalid && wready;
   assign bus.wr_data = wdata;
   assign bus.wr_strb = wstrb;

   ////////////////////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////////////////////

   // arready idles high, drops on any request, returns once data is taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b1;
      end else if (arvalid) begin
         arready <= 1'b0;
      end else if (rvalid && rready) begin
         arready <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rvalid <= 1'b0;
      end else if (arvalid && arready) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   assign bus.rd_en   = arvalid && arready;
   assign bus.rd_addr = araddr;

endmodule

`default_nettype wire

// File: verilog/config_regs.sv
`default_nettype none

module config_regs (
   input  logic                           clk,
   input  logic                           rst_n,
   reg_bus_if.target                      bus,
   output csr_pkg::ctrl_word_u            control,
   output csr_pkg::data_t                 snap_status_raw,
   output csr_pkg::data_t                 snap_context,
   output logic [2*csr_pkg::data_w-1:0]   packet_init_address,
   output logic [2*csr_pkg::data_w-1:0]   stat_init_address,
   output csr_pkg::data_t                 packet_total_number,
   output csr_pkg::data_t                 stat_space_size,
   output logic [2*csr_pkg::data_w-1:0]   self_test
);
   import csr_pkg::*;

   data_t wr_mask;

   // strobed bytes take the new data, the rest keep the old value
   function automatic data_t merge(input data_t old_val, input data_t new_val,
                                   input data_t mask);
      return (new_val & mask) | (old_val & ~mask);
   endfunction

   always_comb begin
      for (int i = 0; i < strb_w; i++) begin
         wr_mask[8*i +: 8] = {8{bus.wr_strb[i]}};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // register file
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         control             <= '0;
         snap_status_raw     <= '0;
         snap_context        <= '0;
         packet_init_address <= '0;
         stat_init_address   <= '0;
         packet_total_number <= '0;
         stat_space_size     <= '0;
         self_test           <= self_test_reset;
      end else if (bus.wr_en) begin
         case (bus.wr_addr)
            addr_snap_status: begin
               snap_status_raw <= merge(snap_status_raw, bus.wr_data, wr_mask);
            end
            addr_snap_context: begin
               snap_context <= merge(snap_context, bus.wr_data, wr_mask);
            end
            addr_control: begin
               control.raw <= merge(control.raw, bus.wr_data, wr_mask);
            end
            // 64-bit registers, one half per access
            addr_packet_init_l: begin
               packet_init_address[data_w-1:0] <=
                  merge(packet_init_address[data_w-1:0], bus.wr_data, wr_mask);
            end
            addr_packet_init_h: begin
               packet_init_address[2*data_w-1:data_w] <=
                  merge(packet_init_address[2*data_w-1:data_w], bus.wr_data, wr_mask);
            end
            addr_stat_init_l: begin
               stat_init_address[data_w-1:0] <=
                  merge(stat_init_address[data_w-1:0], bus.wr_data, wr_mask);
            end
            addr_stat_init_h: begin
               stat_init_address[2*data_w-1:data_w] <=
                  merge(stat_init_address[2*data_w-1:data_w], bus.wr_data, wr_mask);
            end
            addr_packet_total: begin
               packet_total_number <= merge(packet_total_number, bus.wr_data, wr_mask);
            end
            addr_stat_space: begin
               stat_space_size <= merge(stat_space_size, bus.wr_data, wr_mask);
            end
            addr_self_test_l: begin
               self_test[data_w-1:0] <= merge(self_test[data_w-1:0], bus.wr_data, wr_mask);
            end
            addr_self_test_h: begin
               self_test[2*data_w-1:data_w] <=
                  merge(self_test[2*data_w-1:data_w], bus.wr_data, wr_mask);
            end
            default: begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/run_status.sv
`default_nettype none

module run_status (
   input  logic                           clk,
   input  logic                           rst_n,
   input  csr_pkg::ctrl_word_u            control,
   input  csr_pkg::data_t                 snap_status_raw,
   input  csr_pkg::data_t                 stat_total_number,
   input  logic                           packet_exhausted,
   input  logic                           packet_run_out,
   input  logic                           result_space_depleted,
   input  logic                           result_complete,
   input  logic                           result_flush_done,
   input  logic                           input_buffer_valid,
   input  logic [csr_pkg::err_w-1:0]      axi_master_error,
   input  logic                           app_ready,
   output logic [csr_pkg::status_w-1:0]   status,
   output csr_pkg::data_t                 snap_status
);
   import csr_pkg::*;

   logic [status_w-1:0] snapshot_d;
   logic                idle;
   logic                idle_q;
   logic                app_done_q;
   logic                app_start_q;
   logic                start_bit_q;

   // engine inputs packed into the snapshot layout, unused bits stay zero
   always_comb begin
      snapshot_d                                = '0;
      snapshot_d[stat_pos_exhausted]            = packet_exhausted;
      snapshot_d[stat_pos_complete]             = result_complete;
      snapshot_d[stat_pos_flush_done]           = result_flush_done;
      snapshot_d[stat_pos_space_depleted]       = result_space_depleted;
      snapshot_d[stat_pos_buffer_valid]         = input_buffer_valid;
      snapshot_d[stat_pos_run_out]              = packet_run_out;
      snapshot_d[stat_err_lsb +: err_w]         = axi_master_error;
      snapshot_d[stat_total_lsb +: data_w]      = stat_total_number;
   end

   always_ff @(posedge clk) begin
      status <= snapshot_d;
   end

   // both engines disabled
   assign idle = ~(control.bits.packet_enable | control.bits.stat_enable);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idle_q      <= 1'b0;
         app_done_q  <= 1'b0;
         app_start_q <= 1'b0;
         start_bit_q <= 1'b0;
      end else begin
         idle_q      <= idle;
         start_bit_q <= snap_status_raw[0];
         app_done_q  <= status[stat_pos_exhausted] & status[stat_pos_complete];
         // leaving idle ends the run, a rising start bit begins one
         if (idle_q && !idle) begin
            app_start_q <= 1'b0;
         end else if (!start_bit_q && snap_status_raw[0]) begin
            app_start_q <= 1'b1;
         end
      end
   end

   assign snap_status = {snap_status_raw[data_w-1:4], app_ready, idle_q, app_done_q, app_start_q};

endmodule

`default_nettype wire

// File: verilog/read_mux.sv
`default_nettype none

module read_mux (
   input  logic                           clk,
   input  logic                           rst_n,
   reg_bus_if.target                      bus,
   input  csr_pkg::data_t                 snap_status,
   input  csr_pkg::data_t                 snap_context,
   input  logic [csr_pkg::status_w-1:0]   status,
   input  logic [2*csr_pkg::data_w-1:0]   self_test,
   input  csr_pkg::data_t                 action_type,
   input  csr_pkg::data_t                 action_version,
   output csr_pkg::data_t                 rdata
);
   import csr_pkg::*;

   // rdata only moves on an accepted read and holds under back-pressure
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (bus.rd_en) begin
         case (bus.rd_addr)
            addr_snap_status:    rdata <= snap_status;
            addr_action_type:    rdata <= action_type;
            addr_action_version: rdata <= action_version;
            addr_snap_context:   rdata <= snap_context;
            addr_status_l:       rdata <= status[data_w-1:0];
            addr_status_h:       rdata <= status[status_w-1:data_w];
            addr_self_test_l:    rdata <= self_test[data_w-1:0];
            addr_self_test_h:    rdata <= self_test[2*data_w-1:data_w];
            // unmapped addresses and the write-only control register
            default:             rdata <= unmapped_data;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/csr_top.sv
`default_nettype none

module csr_top (
   input  logic                           clk,
   input  logic                           rst_n,

   // AXI-Lite slave
   input  logic                           s_axi_awvalid,
   input  csr_pkg::addr_t                 s_axi_awaddr,
   output logic                           s_axi_awready,
   input  logic                           s_axi_wvalid,
   input  csr_pkg::data_t                 s_axi_wdata,
   input  csr_pkg::strb_t                 s_axi_wstrb,
   output logic                           s_axi_wready,
   output logic [1:0]                     s_axi_bresp,
   output logic                           s_axi_bvalid,
   input  logic                           s_axi_bready,
   input  logic                           s_axi_arvalid,
   input  csr_pkg::addr_t                 s_axi_araddr,
   output logic                           s_axi_arready,
   output csr_pkg::data_t                 s_axi_rdata,
   output logic [1:0]                     s_axi_rresp,
   output logic                           s_axi_rvalid,
   input  logic                           s_axi_rready,

   // engine configuration
   output logic                           packet_enable,
   output logic                           stat_enable,
   output logic                           result_flush,
   output logic                           core_soft_reset,
   output logic                           disable_axi_write,
   output logic [2*csr_pkg::data_w-1:0]   packet_init_address,
   output logic [2*csr_pkg::data_w-1:0]   stat_init_address,
   output csr_pkg::data_t                 packet_total_number,
   output csr_pkg::data_t                 stat_space_size,
   output csr_pkg::data_t                 snap_context,

   // engine status
   input  csr_pkg::data_t                 stat_total_number,
   input  logic                           packet_exhausted,
   input  logic                           packet_run_out,
   input  logic                           result_space_depleted,
   input  logic                           result_complete,
   input  logic                           result_flush_done,
   input  logic                           input_buffer_valid,
   input  logic [csr_pkg::err_w-1:0]      axi_master_error,
   input  logic                           app_ready,
   input  csr_pkg::data_t                 action_type,
   input  csr_pkg::data_t                 action_version
);
   import csr_pkg::*;

   ctrl_word_u              control;
   data_t                   snap_status_raw;
   data_t                   snap_status;
   logic [status_w-1:0]     status;
   logic [2*data_w-1:0]     self_test;

   reg_bus_if reg_bus ();

   ////////////////////////////////////////////////////////////////////////////
   // bus control
   ////////////////////////////////////////////////////////////////////////////

   axil_handshake handshake_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .awvalid (s_axi_awvalid),
      .awaddr  (s_axi_awaddr),
      .awready (s_axi_awready),
      .wvalid  (s_axi_wvalid),
      .wdata   (s_axi_wdata),
      .wstrb   (s_axi_wstrb),
      .wready  (s_axi_wready),
      .bvalid  (s_axi_bvalid),
      .bready  (s_axi_bready),
      .arvalid (s_axi_arvalid),
      .araddr  (s_axi_araddr),
      .arready (s_axi_arready),
      .rvalid  (s_axi_rvalid),
      .rready  (s_axi_rready),
      .bus     (reg_bus.ctrl)
   );

   // every access completes with OKAY
   assign s_axi_bresp = resp_okay;
   assign s_axi_rresp = resp_okay;

   ////////////////////////////////////////////////////////////////////////////
   // datapath
   ////////////////////////////////////////////////////////////////////////////

   config_regs config_regs_inst (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bus                 (reg_bus.target),
      .control             (control),
      .snap_status_raw     (snap_status_raw),
      .snap_context        (snap_context),
      .packet_init_address (packet_init_address),
      .stat_init_address   (stat_init_address),
      .packet_total_number (packet_total_number),
      .stat_space_size     (stat_space_size),
      .self_test           (self_test)
   );

   run_status run_status_inst (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .control               (control),
      .snap_status_raw       (snap_status_raw),
      .stat_total_number     (stat_total_number),
      .packet_exhausted      (packet_exhausted),
      .packet_run_out        (packet_run_out),
      .result_space_depleted (result_space_depleted),
      .result_complete       (result_complete),
      .result_flush_done     (result_flush_done),
      .input_buffer_valid    (input_buffer_valid),
      .axi_master_error      (axi_master_error),
      .app_ready             (app_ready),
      .status                (status),
      .snap_status           (snap_status)
   );

   read_mux read_mux_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .bus            (reg_bus.target),
      .snap_status    (snap_status),
      .snap_context   (snap_context),
      .status         (status),
      .self_test      (self_test),
      .action_type    (action_type),
      .action_version (action_version),
      .rdata          (s_axi_rdata)
   );

   // control fields out to the engines
   assign packet_enable     = control.bits.packet_enable;
   assign stat_enable       = control.bits.stat_enable;
   assign result_flush      = control.bits.result_flush;
   assign core_soft_reset   = control.bits.core_soft_reset;
   assign disable_axi_write = control.bits.disable_axi_write;

endmodule

`default_nettype wire

// File: sim/tb_csr_top.sv
`default_nettype none

module tb_csr_top;
   timeunit 1ns;
   timeprecision 100ps;
   import csr_pkg::*;

   localparam logic [1:0]  op_write  = 2'd0;
   localparam logic [1:0]  op_read   = 2'd1;
   localparam logic [1:0]  op_engine = 2'd2;
   localparam int          wait_max  = 50;
   localparam logic [31:0] type_val  = 32'h1014_0A55;
   localparam logic [31:0] ver_val   = 32'h0000_0103;

   // dyn marks writes with random data and reads checked against the register model
   // on engine rows addr carries the status low word layout with app_ready in bit 31
   // and data carries stat_total_number
   typedef struct packed {
      logic [1:0]  op;
      logic        dyn;
      logic [3:0]  hold;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      logic [31:0] exp;
   } entry_t;

   logic clk, rst_n;
   logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
   logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
   logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
   logic [3:0]  s_axi_wstrb;
   logic [1:0]  s_axi_bresp, s_axi_rresp;
   logic packet_enable, stat_enable, result_flush, core_soft_reset, disable_axi_write;
   logic [63:0] packet_init_address, stat_init_address;
   logic [31:0] packet_total_number, stat_space_size, snap_context;
   logic [31:0] stat_total_number, action_type, action_version;
   logic packet_exhausted, packet_run_out, result_space_depleted, result_complete;
   logic result_flush_done, input_buffer_valid, app_ready;
   logic [15:0] axi_master_error;

   entry_t      table_q[$];
   logic [31:0] model [0:63];

   csr_top csr_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // checking helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s did not rise within %0d cycles", what, wait_max);
      $display("Checks failed");
      $fatal(1);
   endtask

   function automatic logic channel_level(input int ch);
      case (ch)
         0: return s_axi_awready;
         1: return s_axi_wready;
         2: return s_axi_bvalid;
         3: return s_axi_arready;
         default: return s_axi_rvalid;
      endcase
   endfunction

   // returns at a falling edge with the signal high so the handshake lands on the next rise
   task automatic wait_for(input int ch, input string what);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!channel_level(ch)) begin
         cycles++;
         if (cycles == wait_max) report_timeout(what);
         @(negedge clk);
      end
   endtask

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strb);
      logic [31:0] result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   function automatic string output_name(input logic [31:0] addr);
      case (addr)
         addr_snap_context:  return "snap_context";
         addr_control:       return "control outputs";
         addr_packet_init_l: return "packet_init_address low";
         addr_packet_init_h: return "packet_init_address high";
         addr_stat_init_l:   return "stat_init_address low";
         addr_stat_init_h:   return "stat_init_address high";
         addr_packet_total:  return "packet_total_number";
         addr_stat_space:    return "stat_space_size";
         default:            return "";
      endcase
   endfunction

   function automatic logic [31:0] config_word(input logic [31:0] addr);
      case (addr)
         addr_snap_context:  return snap_context;
         addr_control:       return {27'd0, disable_axi_write, core_soft_reset, result_flush,
                                     stat_enable, packet_enable};
         addr_packet_init_l: return packet_init_address[31:0];
         addr_packet_init_h: return packet_init_address[63:32];
         addr_stat_init_l:   return stat_init_address[31:0];
         addr_stat_init_h:   return stat_init_address[63:32];
         addr_packet_total:  return packet_total_number;
         default:            return stat_space_size;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // bus and engine tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
      wait_for(0, "awready");
      @(posedge clk);
      #1;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = data;
      s_axi_wstrb   = strb;
      s_axi_wvalid  = 1'b1;
      wait_for(1, "wready");
      @(posedge clk);
      #1;
      s_axi_wvalid = 1'b0;
      s_axi_bready = 1'b1;
      wait_for(2, "bvalid");
      check_value("bresp", s_axi_bresp, 2'b00);
      @(posedge clk);
      #1;
      s_axi_bready = 1'b0;
   endtask

   task automatic axil_read(input logic [31:0] addr, input logic [3:0] hold,
                            output logic [31:0] data);
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      wait_for(3, "arready");
      @(posedge clk);
      #1;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = (hold == 0);
      wait_for(4, "rvalid");
      data = s_axi_rdata;
      check_value("rresp", s_axi_rresp, 2'b00);
      if (hold != 0) begin
         // response must stay put under back-pressure
         repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_value("rvalid", s_axi_rvalid, 1'b1);
            check_value("rdata", s_axi_rdata, data);
         end
         @(posedge clk);
         #1;
         s_axi_rready = 1'b1;
      end
      @(posedge clk);
      #1;
      s_axi_rready = 1'b0;
   endtask

   // snapshot takes one cycle and app_done one more
   task automatic engine_set(input logic [31:0] word, input logic [31:0] total);
      packet_exhausted      = word[0];
      result_complete       = word[1];
      result_flush_done     = word[2];
      result_space_depleted = word[3];
      input_buffer_valid    = word[4];
      packet_run_out        = word[5];
      axi_master_error      = word[23:8];
      app_ready             = word[31];
      stat_total_number     = total;
      repeat (3) @(posedge clk);
      #1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////////////////////

   task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic dyn, input logic [31:0] exp);
      entry_t e;
      e = '{op_write, dyn, 4'd0, addr, data, strb, exp};
      table_q.push_back(e);
   endtask

   task automatic add_read(input logic [31:0] addr, input logic [31:0] exp,
                           input logic dyn, input logic [3:0] hold);
      entry_t e;
      e = '{op_read, dyn, hold, addr, 32'd0, 4'd0, exp};
      table_q.push_back(e);
   endtask

   task automatic add_engine(input logic [31:0] word, input logic [31:0] total);
      entry_t e;
      e = '{op_engine, 1'b0, 4'd0, word, total, 4'd0, 32'd0};
      table_q.push_back(e);
   endtask

   task automatic build_table();
      add_read(addr_self_test_l, 32'hDEAD_BEEF, 0, 0);
      add_read(addr_self_test_h, 32'h0, 0, 0);
      add_write(addr_self_test_l, 0, 4'b0101, 1, 0);
      add_read(addr_self_test_l, 0, 1, 0);
      add_write(addr_self_test_h, 0, 4'b1110, 1, 0);
      add_read(addr_self_test_h, 0, 1, 0);
      add_write(addr_packet_init_l, 32'h89AB_CDEF, 4'hF, 0, 32'h89AB_CDEF);
      add_write(addr_packet_init_h, 32'h0123_4567, 4'hF, 0, 32'h0123_4567);
      add_write(addr_stat_init_l, 0, 4'hF, 1, 0);
      add_write(addr_stat_init_h, 0, 4'b0011, 1, 0);
      add_write(addr_packet_total, 32'h0000_1000, 4'hF, 0, 32'h0000_1000);
      add_write(addr_stat_space, 0, 4'b1100, 1, 0);
      add_write(addr_snap_context, 32'hCAFE_F00D, 4'hF, 0, 32'hCAFE_F00D);
      add_read(addr_snap_context, 32'hCAFE_F00D, 0, 0);
      add_write(addr_control, 32'h0000_001F, 4'hF, 0, 32'h0000_001F);
      add_read(addr_control, 32'h5A5A_A5A5, 0, 0);
      add_write(addr_control, 32'h0, 4'hF, 0, 32'h0);
      // exhausted, complete, flush done and buffer valid with an error code
      add_engine(32'h00BE_EF17, 32'h1234_5678);
      add_read(addr_status_l, 32'h00BE_EF17, 0, 0);
      add_read(addr_status_h, 32'h1234_5678, 0, 0);
      add_read(addr_snap_status, 32'h6, 0, 0);
      add_write(addr_snap_status, 32'h1, 4'hF, 0, 32'h1);
      add_read(addr_snap_status, 32'h7, 0, 0);
      add_write(addr_control, 32'h1, 4'h1, 0, 32'h1);
      add_read(addr_snap_status, 32'h2, 0, 0);
      add_engine(32'h80BE_EF17, 32'h1234_5678);
      add_read(addr_snap_status, 32'hA, 0, 0);
      add_read(addr_action_type, type_val, 0, 0);
      add_read(addr_action_version, ver_val, 0, 0);
      add_read(32'h04, 32'h5A5A_A5A5, 0, 0);
      add_read(32'h80, 32'h5A5A_A5A5, 0, 0);
      add_read(addr_self_test_l, 0, 1, 4'd5);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      entry_t      e;
      logic [31:0] got;
      logic [31:0] exp;
      logic [31:0] wdata_v;

      void'($urandom(32'h44d5375c));
      rst_n         = 1'b0;
      s_axi_awvalid = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_bready  = 1'b0;
      s_axi_arvalid = 1'b0;
      s_axi_araddr  = '0;
      s_axi_rready  = 1'b0;
      action_type   = type_val;
      action_version = ver_val;
      // engine inputs settle during the three reset cycles
      engine_set(32'h0, 32'h0);
      for (int k = 0; k < 64; k++) begin
         model[k] = '0;
      end
      model[addr_self_test_l[7:2]] = 32'hDEAD_BEEF;
      build_table();

      rst_n = 1'b1;
      @(posedge clk);
      #1;

      check_value("control outputs", config_word(addr_control), 0);
      check_value("packet_init_address", packet_init_address, 0);
      check_value("stat_init_address", stat_init_address, 0);
      check_value("packet_total_number", packet_total_number, 0);
      check_value("stat_space_size", stat_space_size, 0);
      check_value("snap_context", snap_context, 0);
      check_value("bresp", s_axi_bresp, 0);
      check_value("rresp", s_axi_rresp, 0);
      check_value("awready wready bvalid rvalid",
                  {s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_rvalid}, 0);
      check_value("arready", s_axi_arready, 1);

      foreach (table_q[i]) begin
         e = table_q[i];
         case (e.op)
            op_write: begin
               wdata_v = e.dyn ? $urandom : e.data;
               model[e.addr[7:2]] = merge_bytes(model[e.addr[7:2]], wdata_v, e.strb);
               exp = e.dyn ? model[e.addr[7:2]] : e.exp;
               axil_write(e.addr, wdata_v, e.strb);
               if (output_name(e.addr) != "") begin
                  check_value(output_name(e.addr), config_word(e.addr), exp);
               end
            end
            op_read: begin
               exp = e.dyn ? model[e.addr[7:2]] : e.exp;
               axil_read(e.addr, e.hold, got);
               check_value($sformatf("rdata at %h", e.addr), got, exp);
            end
            default: begin
               engine_set(e.addr, e.data);
            end
         endcase
      end

      // 64-bit outputs built from both halves
      check_value("packet_init_address", packet_init_address,
                  {model[addr_packet_init_h[7:2]], model[addr_packet_init_l[7:2]]});
      check_value("stat_init_address", stat_init_address,
                  {model[addr_stat_init_h[7:2]], model[addr_stat_init_l[7:2]]});

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
verilog/csr_pkg.sv
verilog/reg_bus_if.sv
verilog/axil_handshake.sv
verilog/config_regs.sv
verilog/run_status.sv
verilog/read_mux.sv
verilog/csr_top.sv
sim/tb_csr_top.sv

// File: Bender.yml
package:
  name: csr_top

sources:
  - verilog/csr_pkg.sv
  - verilog/reg_bus_if.sv
  - verilog/axil_handshake.sv
  - verilog/config_regs.sv
  - verilog/run_status.sv
  - verilog/read_mux.sv
  - verilog/csr_top.sv
  - target: simulation
    files:
      - sim/tb_csr_top.sv
